/* pwm_channel.sv */
// single pwm generator with period counter and registered duty compare
`timescale 1ns/10ps
`default_nettype none

module pwm_channel import spi_io_pkg::*; (
	input logic clk_core,
	input logic reset_n,
	input pwm_cfg_t cfg,
	output logic pwm
);

	pwm_count_t cnt;
	logic at_end;

	// --------------------------------------------------
	// period counter
	// --------------------------------------------------

	// wraps after period so the repeat time is period+1 cycles
	assign at_end = (cnt >= cfg.period);

	always_ff @(posedge clk_core or negedge reset_n) begin
		if (!reset_n) begin
			cnt <= '0;
		end else if (!cfg.en) begin
			cnt <= '0;
		end else if (at_end) begin
			cnt <= '0;
		end else begin
			cnt <= cnt + 16'd1;
		end
	end

	// --------------------------------------------------
	// duty compare
	// --------------------------------------------------

	// high while the count is below duty and low when disabled
	always_ff @(posedge clk_core or negedge reset_n) begin
		if (!reset_n) begin
			pwm <= 1'b0;
		end else if (!cfg.en) begin
			pwm <= 1'b0;
		end else begin
			pwm <= (cnt < cfg.duty);
		end
	end

endmodule

`default_nettype wire

/* reg_bank.sv */
// spi_io register bank with version, pwm control, pwm channel and gpio bytes
`timescale 1ns/10ps
`default_nettype none
`include "spi_io_config.svh"

module reg_bank import spi_io_pkg::*; (
	input logic clk_core,
	input logic reset_n,
	input reg_req_t reg_req,
	output reg_data_t rd_data,
	input gpio_t gpio_in,
	output gpio_t gpio_out,
	output pwm_cfg_t pwm_cfg [`SPI_IO_PWM_CHANNELS]
);

	localparam int n_pwm_bytes = 4 * `SPI_IO_PWM_CHANNELS;
	localparam int pwm_idx_w = $clog2(n_pwm_bytes);

	reg_data_t pwm_bytes [n_pwm_bytes];
	logic [`SPI_IO_PWM_CHANNELS-1:0] ch_en;
	logic glb_en;
	gpio_t gpio_reg;

	reg_addr_t pwm_off;
	logic [pwm_idx_w-1:0] pwm_idx;
	logic pwm_hit;
	logic addr_valid;

	// --------------------------------------------------
	// address decode
	// --------------------------------------------------
	assign pwm_off = reg_req.addr - `SPI_IO_ADDR_PWM_BASE;
	assign pwm_idx = pwm_off[pwm_idx_w-1:0];
	assign pwm_hit = (reg_req.addr >= `SPI_IO_ADDR_PWM_BASE) &&
		(pwm_off < reg_addr_t'(n_pwm_bytes));
	assign addr_valid = (reg_req.addr <= `SPI_IO_ADDR_LAST);

	// --------------------------------------------------
	// write side
	// --------------------------------------------------

	// version bytes and unused addresses fall through untouched
	always_ff @(posedge clk_core or negedge reset_n) begin
		if (!reset_n) begin
			ch_en <= '0;
			glb_en <= 1'b0;
			gpio_reg <= '0;
			for (int i = 0; i < n_pwm_bytes; i++) begin
				pwm_bytes[i] <= '0;
			end
		end else if (reg_req.wr && addr_valid) begin
			if (reg_req.addr == `SPI_IO_ADDR_PWM_CTRL) begin
				ch_en <= reg_req.data[`SPI_IO_PWM_CHANNELS-1:0];
				glb_en <= reg_req.data[7];
			end
			if (pwm_hit) begin
				pwm_bytes[pwm_idx] <= reg_req.data;
			end
			if (reg_req.addr == `SPI_IO_ADDR_GPIO) begin
				gpio_reg <= reg_req.data[3:0];
			end
		end
	end

	// --------------------------------------------------
	// read mux
	// --------------------------------------------------
	always_comb begin
		rd_data = '0;
		if (addr_valid) begin
			if (pwm_hit) begin
				rd_data = pwm_bytes[pwm_idx];
			end else begin
				case (reg_req.addr)
					7'd0: rd_data = `SPI_IO_VER_L;
					7'd1: rd_data = `SPI_IO_VER_H;
					// bits 6:4 not implemented
					`SPI_IO_ADDR_PWM_CTRL: rd_data = {glb_en, 3'b000, ch_en};
					// live input pins next to the stored outputs
					`SPI_IO_ADDR_GPIO: rd_data = {gpio_in, gpio_reg};
					default: rd_data = '0;
				endcase
			end
		end
	end

	// --------------------------------------------------
	// outputs
	// --------------------------------------------------
	assign gpio_out = gpio_reg;

	// little endian byte pairs per channel
	for (genvar n = 0; n < `SPI_IO_PWM_CHANNELS; n++) begin : g_cfg
		assign pwm_cfg[n] = '{
			en: glb_en & ch_en[n],
			period: {pwm_bytes[4*n+1], pwm_bytes[4*n]},
			duty: {pwm_bytes[4*n+3], pwm_bytes[4*n+2]}
		};
	end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# build and run the spi_io testbench with verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert --timescale 1ns/10ps \
	-f spi_io_top.f --top-module tb_spi_io_top -o tb_spi_io_top
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

./obj_dir/tb_spi_io_top > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "TEST FAILED" "$log"; then
	echo "simulation reported failure, see $log"
	exit 1
fi

if grep -q "TEST PASSED" "$log"; then
	exit 0
fi

echo "no result line found in $log"
exit 1

/* spi_io_chk.sv */
// pwm channel assertion checker bound into every pwm_channel instance
`timescale 1ns/10ps
`default_nettype none

module spi_io_chk import spi_io_pkg::*; (
	input logic clk_core,
	input logic reset_n,
	input logic en,
	input pwm_count_t period,
	input pwm_count_t cnt,
	input logic pwm
);

	// --------------------------------------------------
	// output gating
	// --------------------------------------------------

	// registered output follows the enable one cycle later
	property p_low_when_disabled;
		@(posedge clk_core) disable iff (!reset_n)
			!en |=> !pwm;
	endproperty

	property p_low_in_reset;
		@(posedge clk_core) !reset_n |-> !pwm;
	endproperty

	// --------------------------------------------------
	// counter range
	// --------------------------------------------------
	property p_cnt_in_period;
		@(posedge clk_core) disable iff (!reset_n)
			cnt <= period;
	endproperty

	a_low_when_disabled: assert property (p_low_when_disabled)
		else $error("pwm output high while the channel is disabled");

	a_low_in_reset: assert property (p_low_in_reset)
		else $error("pwm output high during reset");

	a_cnt_in_period: assert property (p_cnt_in_period)
		else $error("pwm counter %0d above period %0d", cnt, period);

endmodule

`default_nettype wire

/* spi_io_config.svh */
// spi_io register map, version bytes and pwm channel count
`ifndef SPI_IO_CONFIG_SVH
`define SPI_IO_CONFIG_SVH

// --------------------------------------------------
// version bytes
// --------------------------------------------------
`define SPI_IO_VER_L 8'h00
`define SPI_IO_VER_H 8'hA1

// --------------------------------------------------
// register addresses
// --------------------------------------------------

// bit 7 global enable, bits 3:0 channel enables
`define SPI_IO_ADDR_PWM_CTRL 7'd2

// four bytes per channel
// period low, period high, duty low, duty high
`define SPI_IO_ADDR_PWM_BASE 7'd4

// stored output nibble low, input pins high
`define SPI_IO_ADDR_GPIO 7'd20

// highest implemented address
`define SPI_IO_ADDR_LAST 7'd20

// --------------------------------------------------
// sizing
// --------------------------------------------------
`define SPI_IO_PWM_CHANNELS 4

`endif

/* spi_io_pkg.sv */
// spi_io shared types for register requests, pwm configuration and slave states
`default_nettype none

package spi_io_pkg;

	// --------------------------------------------------
	// plain vector types
	// --------------------------------------------------
	typedef logic [6:0] reg_addr_t;
	typedef logic [7:0] reg_data_t;
	typedef logic [15:0] pwm_count_t;
	typedef logic [3:0] gpio_t;

	// --------------------------------------------------
	// bundles
	// --------------------------------------------------

	// one access from the spi slave to the bank
	typedef struct packed {
		logic wr;
		reg_addr_t addr;
		reg_data_t data;
	} reg_req_t;

	// per channel pwm settings with the enable already qualified
	typedef struct packed {
		logic en;
		pwm_count_t period;
		pwm_count_t duty;
	} pwm_cfg_t;

	// frame phase of the spi slave
	typedef enum logic [1:0] {
		spi_idle,
		spi_cmd,
		spi_data
	} spi_state_t;

endpackage

`default_nettype wire

/* spi_io_testdata.txt */
# op letter then hex fields, one operation per line
# W addr n bytes = write burst, R addr n bytes = read and expect, G val = set gpio_in
# O val = expect gpio_out, Q val = expect pwm_out, M ch window high = count pwm high cycles
# state after reset
O 0
Q 0
R 00 03 00 A1 00
# pwm bytes 4 to 19 in one burst, read back with auto-increment
W 04 10 11 22 33 44 55 66 77 88 99 AA BB CC DD EE F0 0F
R 04 10 11 22 33 44 55 66 77 88 99 AA BB CC DD EE F0 0F
# version bytes, address 3 and addresses above 20 ignore writes
W 00 02 5A 5A
W 03 01 FF
W 15 03 12 34 56
# address wraps from 7F to 00
W 7F 02 77 88
R 00 04 00 A1 00 00
R 15 03 00 00 00
R 7F 03 00 00 A1
# gpio output nibble and combined readback
W 14 01 A5
O 5
R 14 01 05
G C
R 14 01 C5
O 5
# channel 0 period 19 duty 7, channel 2 period 9 duty 3
W 04 04 13 00 07 00
W 0C 04 09 00 03 00
R 04 04 13 00 07 00
# global enable with channels 0 and 2
W 02 01 85
R 02 01 85
M 0 14 07
M 2 0A 03
M 1 40 00
# channel 0 off, channel 2 keeps running
W 02 01 84
M 0 14 00
M 2 0A 03
# global enable off
W 02 01 04
R 02 01 04
M 2 0A 00
M 0 14 00
# both back on
W 02 01 85
M 0 14 07
M 2 0A 03

/* spi_io_top.f */
+incdir+.
spi_io_pkg.sv
spi_slave.sv
reg_bank.sv
pwm_channel.sv
spi_io_top.sv
spi_io_chk.sv
tb_spi_io_top.sv

/* spi_io_top.sv */
// spi_io top level joining spi slave, register bank and pwm channels
`timescale 1ns/10ps
`default_nettype none
`include "spi_io_config.svh"

module spi_io_top import spi_io_pkg::*; (
	input logic clk_core,
	input logic reset_n,
	input logic sck,
	input logic mosi,
	input logic ssel,
	input gpio_t gpio_in,
	output logic miso,
	output gpio_t gpio_out,
	output logic [`SPI_IO_PWM_CHANNELS-1:0] pwm_out
);

	reg_req_t reg_req;
	reg_data_t rd_data;
	pwm_cfg_t pwm_cfg [`SPI_IO_PWM_CHANNELS];

	// --------------------------------------------------
	// spi front end
	// --------------------------------------------------
	spi_slave u_spi_slave (
		.clk_core(clk_core),
		.reset_n(reset_n),
		.sck(sck),
		.mosi(mosi),
		.ssel(ssel),
		.miso(miso),
		.reg_req(reg_req),
		.rd_data(rd_data)
	);

	// --------------------------------------------------
	// registers
	// --------------------------------------------------
	reg_bank u_reg_bank (
		.clk_core(clk_core),
		.reset_n(reset_n),
		.reg_req(reg_req),
		.rd_data(rd_data),
		.gpio_in(gpio_in),
		.gpio_out(gpio_out),
		.pwm_cfg(pwm_cfg)
	);

	// --------------------------------------------------
	// pwm channels
	// --------------------------------------------------
	for (genvar n = 0; n < `SPI_IO_PWM_CHANNELS; n++) begin : g_pwm
		pwm_channel u_pwm_channel (
			.clk_core(clk_core),
			.reset_n(reset_n),
			.cfg(pwm_cfg[n]),
			.pwm(pwm_out[n])
		);
	end

endmodule

`default_nettype wire

/* spi_slave.sv */
// spi mode 0 slave with command decode and auto-incrementing register address
`timescale 1ns/10ps
`default_nettype none

module spi_slave import spi_io_pkg::*; (
	input logic clk_core,
	input logic reset_n,
	input logic sck,
	input logic mosi,
	input logic ssel,
	output logic miso,
	output reg_req_t reg_req,
	input reg_data_t rd_data
);

	logic [2:0] sck_sync;
	logic [2:0] ssel_sync;
	logic [1:0] mosi_sync;
	logic sck_rise;
	logic sck_fall;
	logic ssel_active;
	logic frame_start;

	logic [2:0] bit_cnt;
	logic byte_done;
	reg_data_t rx_shift;
	reg_data_t tx_shift;

	spi_state_t state;
	logic wr_dir;
	reg_addr_t addr;
	logic wr_stb;
	logic rd_ld;

	// --------------------------------------------------
	// input synchronizers and edge detect
	// --------------------------------------------------

	// bits 1:0 synchronize and bit 2 holds the previous level
	always_ff @(posedge clk_core or negedge reset_n) begin
		if (!reset_n) begin
			sck_sync <= 3'b000;
			ssel_sync <= 3'b111;
			mosi_sync <= 2'b00;
		end else begin
			sck_sync <= {sck_sync[1:0], sck};
			ssel_sync <= {ssel_sync[1:0], ssel};
			mosi_sync <= {mosi_sync[0], mosi};
		end
	end

	assign sck_rise = (sck_sync[2:1] == 2'b01);
	assign sck_fall = (sck_sync[2:1] == 2'b10);
	assign ssel_active = ~ssel_sync[1];
	assign frame_start = (ssel_sync[2:1] == 2'b10);

	// --------------------------------------------------
	// bit counter and receive shift
	// --------------------------------------------------
	always_ff @(posedge clk_core or negedge reset_n) begin
		if (!reset_n) begin
			bit_cnt <= 3'd0;
			byte_done <= 1'b0;
		end else begin
			byte_done <= 1'b0;
			if (frame_start) begin
				bit_cnt <= 3'd0;
			end else if (ssel_active && sck_rise) begin
				bit_cnt <= bit_cnt + 3'd1;
				byte_done <= (bit_cnt == 3'd7);
			end
		end
	end

	// msb first
	always_ff @(posedge clk_core) begin
		if (ssel_active && sck_rise) begin
			rx_shift <= {rx_shift[6:0], mosi_sync[1]};
		end
	end

	// --------------------------------------------------
	// frame fsm and address counter
	// --------------------------------------------------
	always_ff @(posedge clk_core or negedge reset_n) begin
		if (!reset_n) begin
			state <= spi_idle;
			wr_dir <= 1'b0;
			addr <= '0;
			wr_stb <= 1'b0;
			rd_ld <= 1'b0;
		end else begin
			wr_stb <= 1'b0;
			rd_ld <= 1'b0;
			// step past the byte just written or fetched
			if (wr_stb || rd_ld) begin
				addr <= addr + 7'd1;
			end
			if (!ssel_active) begin
				state <= spi_idle;
			end else begin
				case (state)
					spi_idle: begin
						if (frame_start) begin
							state <= spi_cmd;
						end
					end
					spi_cmd: begin
						if (byte_done) begin
							wr_dir <= rx_shift[7];
							addr <= rx_shift[6:0];
							// prefetch the start address for a read
							rd_ld <= ~rx_shift[7];
							state <= spi_data;
						end
					end
					spi_data: begin
						if (byte_done) begin
							wr_stb <= wr_dir;
							rd_ld <= ~wr_dir;
						end
					end
					default: state <= spi_idle;
				endcase
			end
		end
	end

	// --------------------------------------------------
	// transmit shift
	// --------------------------------------------------

	// no shift on the first falling edge so the msb stays on miso
	always_ff @(posedge clk_core or negedge reset_n) begin
		if (!reset_n) begin
			tx_shift <= '0;
		end else if (frame_start) begin
			tx_shift <= '0;
		end else if (rd_ld) begin
			tx_shift <= rd_data;
		end else if (ssel_active && sck_fall && (bit_cnt != 3'd0)) begin
			tx_shift <= {tx_shift[6:0], 1'b0};
		end
	end

	assign miso = tx_shift[7];
	assign reg_req = '{wr: wr_stb, addr: addr, data: rx_shift};

endmodule

`default_nettype wire

/* tb_spi_io_top.sv */
// testbench for the spi_io block driving spi bursts and pwm measurements from a data file
`timescale 1ns/10ps
`default_nettype none
`include "spi_io_config.svh"

module tb_spi_io_top import spi_io_pkg::*; ();

	logic clk_core = 1'b0;
	logic reset_n;
	logic sck;
	logic mosi;
	logic ssel;
	gpio_t gpio_in;
	logic miso;
	gpio_t gpio_out;
	logic [`SPI_IO_PWM_CHANNELS-1:0] pwm_out;

	int n_errors = 0;
	int n_checks = 0;
	int cycle_count = 0;
	int cycle_limit = 0;
	reg_data_t tx_q [$];
	reg_data_t rx_q [$];

	spi_io_top uut (
		.clk_core(clk_core),
		.reset_n(reset_n),
		.sck(sck),
		.mosi(mosi),
		.ssel(ssel),
		.gpio_in(gpio_in),
		.miso(miso),
		.gpio_out(gpio_out),
		.pwm_out(pwm_out)
	);

	bind pwm_channel spi_io_chk u_chk (
		.clk_core(clk_core),
		.reset_n(reset_n),
		.en(cfg.en),
		.period(cfg.period),
		.cnt(cnt),
		.pwm(pwm)
	);

	always #4 clk_core = ~clk_core;

	// --------------------------------------------------
	// helpers
	// --------------------------------------------------

	// inputs change 1 ns after the rising edge
	task automatic wait_cycles(input int n);
		repeat (n) begin
			@(posedge clk_core);
			#1;
		end
	endtask

	task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
		n_checks++;
		if (got !== exp) begin
			$display("mismatch at %0t: %s, got %0h, expected %0h", $time, what, got, exp);
			n_errors++;
		end
	endtask

	// mode 0 with a half period of four core cycles and miso taken on the rising sck edge
	task automatic spi_byte(input reg_data_t tx, output reg_data_t rx);
		for (int i = 7; i >= 0; i--) begin
			mosi = tx[i];
			wait_cycles(4);
			sck = 1'b1;
			rx[i] = miso;
			wait_cycles(4);
			sck = 1'b0;
		end
	endtask

	// command byte then n data bytes with the received bytes kept in rx_q
	task automatic spi_frame(input logic wr, input reg_addr_t addr, input int n_bytes);
		reg_data_t rx;
		reg_data_t tx;
		rx_q.delete();
		ssel = 1'b0;
		spi_byte({wr, addr}, rx);
		for (int i = 0; i < n_bytes; i++) begin
			tx = wr ? tx_q[i] : 8'h00;
			spi_byte(tx, rx);
			rx_q.push_back(rx);
		end
		wait_cycles(4);
		ssel = 1'b1;
		mosi = 1'b0;
		wait_cycles(8);
	endtask

	// --------------------------------------------------
	// watchdog
	// --------------------------------------------------
	initial begin : watchdog
		wait (cycle_limit != 0);
		while (cycle_count < cycle_limit) begin
			@(posedge clk_core);
			cycle_count++;
		end
		$display("timeout: run did not finish within %0d cycles, %0d errors so far",
			cycle_limit, n_errors);
		$display("TEST FAILED");
		$finish;
	end

	// --------------------------------------------------
	// main sequence
	// --------------------------------------------------
	initial begin : main
		int fd;
		int code;
		int n_lines;
		int addr_f;
		int n_f;
		int byte_f;
		int ch_f;
		int exp_f;
		int val_f;
		int high_cnt;
		logic [7:0] op;
		logic [8*128-1:0] line_buf;

		n_lines = 0;
		reset_n = 1'b0;
		sck = 1'b0;
		mosi = 1'b0;
		ssel = 1'b1;
		gpio_in = '0;

		// first pass only sizes the run time
		fd = $fopen("spi_io_testdata.txt", "r");
		if (fd == 0) begin
			$display("error: cannot open spi_io_testdata.txt");
			n_errors++;
		end else begin
			while ($fgets(line_buf, fd) != 0) begin
				n_lines++;
			end
			$fclose(fd);
			cycle_limit = n_lines * 400;
			fd = $fopen("spi_io_testdata.txt", "r");
		end

		wait_cycles(8);
		reset_n = 1'b1;
		wait_cycles(4);

		if (fd != 0) begin
			while ($fscanf(fd, " %c", op) == 1) begin
				case (op)
					"#": code = $fgets(line_buf, fd);
					"W", "R": begin
						code = $fscanf(fd, "%h %h", addr_f, n_f);
						if (code != 2) begin
							$display("error: short %c line in spi_io_testdata.txt", op);
							n_errors++;
							n_f = 0;
						end
						tx_q.delete();
						for (int i = 0; i < n_f; i++) begin
							code = $fscanf(fd, "%h", byte_f);
							if (code != 1) begin
								$display("error: short %c line in spi_io_testdata.txt", op);
								n_errors++;
							end
							tx_q.push_back(byte_f[7:0]);
						end
						spi_frame(op == "W", reg_addr_t'(addr_f), n_f);
						if (op == "R") begin
							for (int i = 0; i < n_f; i++) begin
								check_value(32'(rx_q[i]), 32'(tx_q[i]),
									$sformatf("read of address %02h", 7'(addr_f + i)));
							end
						end
					end
					"G": begin
						code = $fscanf(fd, "%h", val_f);
						if (code != 1) begin
							$display("error: short %c line in spi_io_testdata.txt", op);
							n_errors++;
						end
						gpio_in = val_f[3:0];
						wait_cycles(1);
					end
					"O": begin
						code = $fscanf(fd, "%h", val_f);
						if (code != 1) begin
							$display("error: short %c line in spi_io_testdata.txt", op);
							n_errors++;
						end
						check_value(32'(gpio_out), val_f, "gpio_out");
					end
					"Q": begin
						code = $fscanf(fd, "%h", val_f);
						if (code != 1) begin
							$display("error: short %c line in spi_io_testdata.txt", op);
							n_errors++;
						end
						check_value(32'(pwm_out), val_f, "pwm_out");
					end
					"M": begin
						code = $fscanf(fd, "%h %h %h", ch_f, n_f, exp_f);
						if (code != 3) begin
							$display("error: short %c line in spi_io_testdata.txt", op);
							n_errors++;
						end
						wait_cycles(4);
						high_cnt = 0;
						repeat (n_f) begin
							wait_cycles(1);
							if (pwm_out[ch_f[1:0]]) begin
								high_cnt++;
							end
						end
						check_value(high_cnt, exp_f,
							$sformatf("high cycles of pwm channel %0d", ch_f));
					end
					default: begin
						$display("error: unknown operation %c in spi_io_testdata.txt", op);
						n_errors++;
						code = $fgets(line_buf, fd);
					end
				endcase
			end
			$fclose(fd);
		end

		$display("checks: %0d, errors: %0d", n_checks, n_errors);
		if (n_errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire
